// File: vec_mem_pkg.sv
package vec_mem_pkg;

    // Vector geometry
    localparam int VEC_I  = 20;     // Elements per vector
    localparam int ELEM_L = 8;      // Element width
    localparam int ADDR_A = 32;     // External address width

    // RAM geometry, only the low address bits reach the array
    localparam int RAM_AW    = 8;
    localparam int RAM_DEPTH = 1 << RAM_AW;

    // Counter must reach VEC_I itself, not just VEC_I-1
    localparam int CNT_W = $clog2(VEC_I + 1);

    typedef logic [ELEM_L-1:0] elem_t;
    typedef elem_t [VEC_I-1:0] vec_t;      // Element 0 sits in the low bits
    typedef logic [RAM_AW-1:0] ram_addr_t;
    typedef logic [CNT_W-1:0]  cnt_t;      // Element index or element count

    // Scalar view of the write word
    typedef struct packed {
        logic [(VEC_I-1)*ELEM_L-1:0] pad;  // Unused upper part
        elem_t                       elem; // The scalar itself
    } sca_word_t;

    // Write word, read as a full vector or as one scalar
    typedef union packed {
        vec_t      vec;
        sca_word_t sca;
    } wr_word_u;

endpackage

// File: mem_if.sv
`timescale 1ns/1ps

// Operation descriptor from decode to the sequencer and the collector
interface mem_req_if;
    import vec_mem_pkg::*;

    logic      go;         // One-cycle start pulse
    logic      is_write;   // Store when set, load otherwise
    logic      is_vector;  // Vector when set, scalar otherwise
    ram_addr_t base;       // First RAM word
    cnt_t      count;      // 1 or VEC_I
    wr_word_u  wdata;      // Store payload

    modport decode (
        output go, is_write, is_vector, base, count, wdata
    );

    modport sequencer (
        input go, is_write, is_vector, base, count, wdata
    );

    // Collector only needs the start pulse and the shape
    modport result (
        input go, is_vector
    );

endinterface

// Read return path into the collector
interface mem_rd_if;
    import vec_mem_pkg::*;

    logic  rd_valid;   // RAM data valid this cycle
    cnt_t  rd_idx;     // Element the data belongs to
    logic  rd_last;    // Final element of the load
    elem_t rd_data;    // Straight from the RAM output register

    // rd_data comes from the RAM, not from the sequencer
    modport sequencer (
        output rd_valid, rd_idx, rd_last
    );

    modport result (
        input rd_valid, rd_idx, rd_last, rd_data
    );

endinterface

// File: mem_op_decode.sv
`timescale 1ns/1ps

module mem_op_decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           mem_en,
    input  logic                           op_type,       // 1 vector, 0 scalar
    input  logic                           op_source,     // 1 ALU, 0 register file
    input  logic                           write_enable,  // 1 store, 0 load
    input  logic [vec_mem_pkg::ADDR_A-1:0] address,
    input  vec_mem_pkg::vec_t              alu_vec,
    input  vec_mem_pkg::vec_t              reg_vec,
    input  vec_mem_pkg::elem_t             alu_sca,
    input  vec_mem_pkg::elem_t             reg_sca,
    mem_req_if.decode                      req
);
    import vec_mem_pkg::*;

    logic      busy;       // mem_en seen high on the previous edge
    logic      start;      // Idle to active edge of mem_en
    vec_t      src_vec;
    elem_t     src_sca;
    wr_word_u  wword;      // Write word being assembled

    assign start = mem_en && !busy;

    // Source selection, same polarity for both shapes
    assign src_vec = op_source ? alu_vec : reg_vec;
    assign src_sca = op_source ? alu_sca : reg_sca;

    // Fill the union through whichever view matches the operation
    always_comb begin
        wword = '0;
        if (op_type) begin
            wword.vec = src_vec;
        end else begin
            wword.sca.pad  = '0;
            wword.sca.elem = src_sca;
        end
    end

    // Control part of the descriptor
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            req.go        <= 1'b0;
            req.is_write  <= 1'b0;
            req.is_vector <= 1'b0;
            req.count     <= '0;
        end else begin
            busy   <= mem_en;  // Drops one edge after mem_en does
            req.go <= start;
            if (start) begin
                req.is_write  <= write_enable;
                req.is_vector <= op_type;
                req.count     <= op_type ? cnt_t'(VEC_I) : cnt_t'(1);
            end
        end
    end

    // Payload, held until the next start
    always_ff @(posedge clk) begin
        if (start) begin
            req.base  <= address[RAM_AW-1:0];  // Upper bits dropped, addresses wrap
            req.wdata <= wword;
        end
    end

endmodule

// File: mem_access_seq.sv
`timescale 1ns/1ps

module mem_access_seq (
    input  logic                   clk,
    input  logic                   rst_n,
    mem_req_if.sequencer           req,
    mem_rd_if.sequencer            rd,
    output vec_mem_pkg::ram_addr_t ram_addr,
    output logic                   ram_we,
    output vec_mem_pkg::elem_t     ram_wdata,
    output logic                   wr_done
);
    import vec_mem_pkg::*;

    logic  busy;        // Elements after the first still to issue
    cnt_t  idx;         // Next element while busy
    logic  issue_now;
    cnt_t  issue_idx;
    logic  issue_last;
    elem_t issue_elem;

    // Read issued this cycle, waiting on the RAM register
    logic  iss_rd;
    cnt_t  iss_idx;
    logic  iss_last;

    // Element 0 goes out in the cycle right after go
    assign issue_now  = req.go || busy;
    assign issue_idx  = req.go ? cnt_t'(0) : idx;
    assign issue_last = (issue_idx == req.count - cnt_t'(1));

    // Pick the element through the view that fits the shape
    always_comb begin
        if (req.is_vector) begin
            issue_elem = req.wdata.vec[issue_idx];
        end else begin
            issue_elem = req.wdata.sca.elem;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            idx         <= '0;
            ram_we      <= 1'b0;
            wr_done     <= 1'b0;
            iss_rd      <= 1'b0;
            rd.rd_valid <= 1'b0;
        end else begin
            busy    <= issue_now && !issue_last;
            idx     <= issue_idx + cnt_t'(1);
            ram_we  <= issue_now && req.is_write;
            wr_done <= issue_now && req.is_write && issue_last;  // With the last write
            iss_rd  <= issue_now && !req.is_write;
            rd.rd_valid <= iss_rd;  // RAM data lands one edge later
        end
    end

    // Address and data registers
    always_ff @(posedge clk) begin
        if (issue_now) begin
            ram_addr  <= req.base + ram_addr_t'(issue_idx);  // Wraps modulo RAM_DEPTH
            ram_wdata <= issue_elem;
        end
    end

    // Tag pipeline, two stages to meet the registered RAM read
    always_ff @(posedge clk) begin
        iss_idx    <= issue_idx;
        iss_last   <= issue_last;
        rd.rd_idx  <= iss_idx;
        rd.rd_last <= iss_last;  // Only meaningful with rd_valid
    end

endmodule

// File: data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic                   clk,
    input  vec_mem_pkg::ram_addr_t addr,
    input  logic                   we,
    input  vec_mem_pkg::elem_t     wdata,
    output vec_mem_pkg::elem_t     rdata
);
    import vec_mem_pkg::*;

    // Storage array, one element per word
    elem_t mem [RAM_DEPTH];

    // Rising-edge write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Registered read every cycle, old data on a write to the same word
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

// File: mem_result_collect.sv
`timescale 1ns/1ps

module mem_result_collect (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_en,
    mem_req_if.result          req,
    mem_rd_if.result           rd,
    input  logic               wr_done,
    output vec_mem_pkg::elem_t scalar_output,
    output vec_mem_pkg::vec_t  vector_output,
    output logic               mem_finished
);
    import vec_mem_pkg::*;

    logic  rd_done;       // Last load element returning
    vec_t  vec_q;         // Vector result register
    elem_t sca_q;         // Scalar result register

    assign rd_done = rd.rd_valid && rd.rd_last;

    // Vector assembly, one element per return
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vec_q <= '0;
        end else if (req.go) begin
            vec_q <= '0;  // Fresh result per operation
        end else if (rd.rd_valid && req.is_vector) begin
            vec_q[rd.rd_idx] <= rd.rd_data;
        end
    end

    // Scalar load lands here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sca_q <= '0;
        end else if (rd.rd_valid && !req.is_vector) begin
            sca_q <= rd.rd_data;
        end
    end

    // Finish level
    // Set with the final element or the last write, held while mem_en stays high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_finished <= 1'b0;
        end else if (!mem_en) begin
            mem_finished <= 1'b0;
        end else if (rd_done || wr_done) begin
            mem_finished <= 1'b1;
        end
    end

    assign scalar_output = sca_q;
    assign vector_output = vec_q;  // Updates on the same edge as mem_finished

endmodule

// File: mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           mem_en,        // Level, held for the whole operation
    input  logic                           op_type,       // 1 vector, 0 scalar
    input  logic                           op_source,     // 1 ALU, 0 register file
    input  logic                           write_enable,  // 1 store, 0 load
    input  logic [vec_mem_pkg::ADDR_A-1:0] address,
    input  vec_mem_pkg::vec_t              alu_vec,
    input  vec_mem_pkg::vec_t              reg_vec,
    input  vec_mem_pkg::elem_t             alu_sca,
    input  vec_mem_pkg::elem_t             reg_sca,
    output vec_mem_pkg::elem_t             scalar_output,
    output vec_mem_pkg::vec_t              vector_output,
    output vec_mem_pkg::elem_t             mem_data,      // Raw RAM read word
    output logic                           mem_finished
);
    import vec_mem_pkg::*;

    // RAM side
    ram_addr_t ram_addr;
    logic      ram_we;
    elem_t     ram_wdata;
    elem_t     ram_rdata;

    logic      wr_done;   // Last store element issued

    mem_req_if req_if ();
    mem_rd_if  rd_if ();

    // RAM output goes both to the collector and straight out
    assign rd_if.rd_data = ram_rdata;
    assign mem_data      = ram_rdata;

    mem_op_decode mem_op_decode_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_en       (mem_en),
        .op_type      (op_type),
        .op_source    (op_source),
        .write_enable (write_enable),
        .address      (address),
        .alu_vec      (alu_vec),
        .reg_vec      (reg_vec),
        .alu_sca      (alu_sca),
        .reg_sca      (reg_sca),
        .req          (req_if.decode)
    );

    mem_access_seq mem_access_seq_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req_if.sequencer),
        .rd        (rd_if.sequencer),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_wdata (ram_wdata),
        .wr_done   (wr_done)
    );

    data_ram data_ram_i (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mem_result_collect mem_result_collect_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_en        (mem_en),
        .req           (req_if.result),
        .rd            (rd_if.result),
        .wr_done       (wr_done),
        .scalar_output (scalar_output),
        .vector_output (vector_output),
        .mem_finished  (mem_finished)
    );

endmodule

// File: mem_stage_assertions.sv
`timescale 1ns/1ps

module mem_stage_assertions (
    input logic clk,
    input logic rst_n,
    input logic mem_en,
    input logic go,            // Start pulse from decode
    input logic seq_busy,      // Sequencer still issuing elements
    input logic ram_we,
    input logic mem_finished
);

    int fail_count;            // Read by the testbench at the end

    initial fail_count = 0;

    // No RAM write outside an operation
    ram_we_only_when_enabled: assert property (
        @(posedge clk) disable iff (!rst_n)
        !mem_en |-> !ram_we
    ) else begin
        fail_count++;
        $error("ram_we high while mem_en is low");
    end

    // Finish level only once the sequencer has gone quiet
    finish_after_issue: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(mem_finished) |-> (!go && !seq_busy && !ram_we)
    ) else begin
        fail_count++;
        $error("mem_finished rose with an operation still in progress");
    end

    // mem_en is a level that must outlast the operation
    enable_held_to_finish: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(mem_en) |-> mem_finished
    ) else begin
        fail_count++;
        $error("mem_en dropped before mem_finished");
    end

endmodule

// File: tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;
    import vec_mem_pkg::*;

    localparam int NUM_OPS    = 8 + 4 + 3 + 3 + 20;   // All operations of the run
    localparam int MAX_CYCLES = NUM_OPS * 30 + 20;    // 30 per operation plus reset margin

    logic              clk;
    logic              rst_n;
    logic              mem_en;
    logic              op_type;
    logic              op_source;
    logic              write_enable;
    logic [ADDR_A-1:0] address;
    vec_t              alu_vec;
    vec_t              reg_vec;
    elem_t             alu_sca;
    elem_t             reg_sca;
    elem_t             scalar_output;
    vec_t              vector_output;
    elem_t             mem_data;
    logic              mem_finished;

    elem_t  model [RAM_DEPTH];     // Reference copy of the data RAM
    integer seed;
    int     value_errors;
    int     latency_errors;
    int     cycle_count;
    int     op_cycles;             // Edges since mem_en went high

    // Expectation for the running operation
    string  cur_name;
    logic   cur_write;
    logic   cur_vector;
    vec_t   exp_vec;
    elem_t  exp_last;
    int     exp_cycles;
    logic   fin_prev;

    bind mem_stage mem_stage_assertions mem_stage_assertions_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_en       (mem_en),
        .go           (req_if.go),
        .seq_busy     (mem_access_seq_i.busy),
        .ram_we       (mem_access_seq_i.ram_we),
        .mem_finished (mem_result_collect_i.mem_finished)
    );

    mem_stage mem_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Expected load result with addresses wrapped on the low RAM_AW bits
    function automatic vec_t expected_load(logic [ADDR_A-1:0] addr, logic vector);
        vec_t v;
        int   n;
        v = '0;
        n = vector ? VEC_I : 1;
        for (int k = 0; k < n; k++) begin
            v[k] = model[(addr + k) % RAM_DEPTH];
        end
        return v;
    endfunction

    // Model update for a store with the source picked by op_source
    task automatic apply_store(logic [ADDR_A-1:0] addr, logic vector, logic source);
        vec_t data;
        int   n;
        data = source ? alu_vec : reg_vec;
        if (!vector) begin
            data[0] = source ? alu_sca : reg_sca;
        end
        n = vector ? VEC_I : 1;
        for (int k = 0; k < n; k++) begin
            model[(addr + k) % RAM_DEPTH] = data[k];
        end
    endtask

    task automatic draw_operands();
        for (int k = 0; k < VEC_I; k++) begin
            alu_vec[k] = elem_t'($random(seed));
            reg_vec[k] = elem_t'($random(seed));
        end
        alu_sca = elem_t'($random(seed));
        reg_sca = elem_t'($random(seed));
    endtask

    // Starts on a falling edge and returns after one cycle with mem_en low
    task automatic run_operation(string name, logic write, logic vector, logic source,
                                 logic [ADDR_A-1:0] addr);
        int n;
        n = vector ? VEC_I : 1;
        draw_operands();
        cur_name   = name;
        cur_write  = write;
        cur_vector = vector;
        exp_cycles = write ? n + 2 : n + 3;
        if (write) begin
            apply_store(addr, vector, source);
        end else begin
            exp_vec  = expected_load(addr, vector);
            exp_last = exp_vec[n-1];   // Last word read stays on mem_data
        end
        op_type      = vector;
        op_source    = source;
        write_enable = write;
        address      = addr;
        mem_en       = 1'b1;
        do @(negedge clk); while (!mem_finished);
        repeat (2) begin   // Level must hold while mem_en does
            @(negedge clk);
            assert (mem_finished) else begin
                latency_errors++;
                $display("mem_finished dropped while mem_en was high in %s", name);
            end
        end
        mem_en = 1'b0;
        @(negedge clk);
        assert (!mem_finished) else begin
            latency_errors++;
            $display("mem_finished still high after mem_en dropped in %s", name);
        end
    endtask

    always @(posedge clk) begin
        op_cycles <= mem_en ? op_cycles + 1 : 0;
    end

    // Compare on the first falling edge that sees mem_finished high
    always @(negedge clk) begin
        if (mem_finished && !fin_prev) begin
            assert (op_cycles == exp_cycles) else begin
                latency_errors++;
                $display("CHECK FAILED %s latency: expected %0d, actual %0d",
                         cur_name, exp_cycles, op_cycles);
            end
            if (!cur_write && cur_vector) begin
                assert (vector_output === exp_vec) else begin
                    value_errors++;
                    $display("CHECK FAILED %s vector: expected %h, actual %h",
                             cur_name, exp_vec, vector_output);
                end
            end
            if (!cur_write && !cur_vector) begin
                assert (scalar_output === exp_vec[0]) else begin
                    value_errors++;
                    $display("CHECK FAILED %s scalar: expected %h, actual %h",
                             cur_name, exp_vec[0], scalar_output);
                end
            end
            if (!cur_write) begin
                assert (mem_data === exp_last) else begin
                    value_errors++;
                    $display("CHECK FAILED %s mem_data: expected %h, actual %h",
                             cur_name, exp_last, mem_data);
                end
            end
        end
        fin_prev = mem_finished;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, an operation never finished", cycle_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0]       r;
        logic [ADDR_A-1:0] addr;
        int                sva_fails;
        seed           = 32'hf041;
        value_errors   = 0;
        latency_errors = 0;
        cycle_count    = 0;
        op_cycles      = 0;
        fin_prev       = 1'b0;
        exp_cycles     = 0;
        rst_n          = 1'b0;
        mem_en         = 1'b0;
        op_type        = 1'b0;
        op_source      = 1'b0;
        write_enable   = 1'b0;
        address        = '0;
        alu_vec        = '0;
        reg_vec        = '0;
        alu_sca        = '0;
        reg_sca        = '0;
        repeat (2) @(negedge clk);   // Two reset edges
        rst_n = 1'b1;
        assert (!mem_finished && vector_output == '0 && scalar_output == '0) else begin
            value_errors++;
            $display("CHECK FAILED reset: expected %b %h %h, actual %b %h %h",
                     1'b0, elem_t'(0), vec_t'(0),
                     mem_finished, scalar_output, vector_output);
        end

        // Scalar pairs with alternating source
        for (int i = 0; i < 4; i++) begin
            addr = $random(seed);
            run_operation($sformatf("scalar store %0d", i), 1'b1, 1'b0, i[0], addr);
            run_operation($sformatf("scalar load %0d", i), 1'b0, 1'b0, 1'b0, addr);
        end

        for (int i = 0; i < 2; i++) begin
            addr = $random(seed);
            run_operation($sformatf("vector store %0d", i), 1'b1, 1'b1, i[0], addr);
            run_operation($sformatf("vector load %0d", i), 1'b0, 1'b1, 1'b0, addr);
        end

        // Wrap past the top with different upper bits on each access
        r = $random(seed);
        run_operation("wrap store", 1'b1, 1'b1, 1'b1, {r[31:8], 8'hf5});
        run_operation("wrap load", 1'b0, 1'b1, 1'b0, {~r[31:8], 8'hf5});
        run_operation("wrap scalar", 1'b0, 1'b0, 1'b0, {r[23:0], 8'h03});   // Element 14

        // Defined window 0x40..0x7b for the random mix
        run_operation("fill 0", 1'b1, 1'b1, 1'b1, 32'h40);
        run_operation("fill 1", 1'b1, 1'b1, 1'b0, 32'h54);
        run_operation("fill 2", 1'b1, 1'b1, 1'b1, 32'h68);
        for (int i = 0; i < 20; i++) begin
            r    = $random(seed);
            addr = {r[31:8], 8'h40 + 8'(r[5:0] % 6'd40)};
            run_operation($sformatf("random op %0d", i), r[6], r[7], r[8], addr);
        end

        sva_fails = mem_stage_i.mem_stage_assertions_i.fail_count;
        $display("Errors: value %0d, latency %0d, assertion %0d",
                 value_errors, latency_errors, sva_fails);
        if (value_errors + latency_errors + sva_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
vec_mem_pkg.sv
mem_if.sv
mem_op_decode.sv
mem_access_seq.sv
data_ram.sv
mem_result_collect.sv
mem_stage.sv
mem_stage_assertions.sv
tb_mem_stage.sv
